// File: include/ldst_consts.svh
// Load/store unit constants

`ifndef LDST_CONSTS_SVH
`define LDST_CONSTS_SVH

// Data and address width
`define LDST_XLEN 64

// Physical register tag width
`define LDST_PRF_IDX_W 6

// ROB index width
`define LDST_ROB_IDX_W 5

// Store queue depth, power of two
`define LDST_SQ_DEPTH 4
`define LDST_SQ_IDX_W 2

`endif

// File: source/ldst_pkg.sv
// Load/store unit types

`default_nettype none

package ldst_pkg;

  // Memory operation from issue
  typedef enum logic [1:0] {
    MEM_NOP = 2'd0,
    MEM_LD  = 2'd1,
    MEM_ST  = 2'd2
  } mem_op_e;

  // Load unit FSM
  typedef enum logic [1:0] {
    LD_IDLE    = 2'd0,
    LD_WAIT    = 2'd1,  // Read outstanding
    LD_DISCARD = 2'd2   // Flushed, eat the ack
  } ld_state_e;

endpackage

`default_nettype wire

// File: source/ldst_agen.sv
// Address generation stage

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module ldst_agen (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       flush_i,
  input  wire ldst_pkg::mem_op_e          op_i,
  input  wire logic [`LDST_XLEN-1:0]      opa_i,
  input  wire logic [`LDST_XLEN-1:0]      opb_i,
  input  wire logic [15:0]                imm_i,
  input  wire logic [`LDST_PRF_IDX_W-1:0] dest_tag_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] rob_idx_i,
  output ldst_pkg::mem_op_e               op_o,
  output logic [`LDST_XLEN-1:0]           addr_o,
  output logic [`LDST_XLEN-1:0]           data_o,
  output logic [`LDST_PRF_IDX_W-1:0]      dest_tag_o,
  output logic [`LDST_ROB_IDX_W-1:0]      rob_idx_o
);

  import ldst_pkg::*;

  logic [`LDST_XLEN-1:0] disp;

  assign disp = {{(`LDST_XLEN-16){imm_i[15]}}, imm_i};  // Sign-extended displacement

  always_ff @(posedge clk) begin
    if (rst) begin
      op_o <= MEM_NOP;
    end else if (flush_i) begin
      op_o <= MEM_NOP;
    end else begin
      op_o <= op_i;
    end
  end

  // Payload, qualified by op_o
  always_ff @(posedge clk) begin
    addr_o     <= opb_i + disp;
    data_o     <= opa_i;
    dest_tag_o <= dest_tag_i;
    rob_idx_o  <= rob_idx_i;
  end

endmodule

`default_nettype wire

// File: source/store_queue.sv
// Circular store queue

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module store_queue (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       flush_i,
  input  wire ldst_pkg::mem_op_e          op_i,
  input  wire logic [`LDST_XLEN-1:0]      addr_i,
  input  wire logic [`LDST_XLEN-1:0]      data_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] rob_idx_i,
  input  wire logic                       rob_st_retire_i,
  input  wire logic [`LDST_XLEN-1:0]      fwd_addr_i,
  input  wire logic                       dc_st_stall_i,
  output logic                            fwd_hit_o,
  output logic [`LDST_XLEN-1:0]           fwd_data_o,
  output logic                            st_acc_o,
  output logic [`LDST_ROB_IDX_W-1:0]      st_rob_idx_o,
  output logic                            sq_full_o,
  output logic                            dc_st_en_o,
  output logic [`LDST_XLEN-1:0]           dc_st_addr_o,
  output logic [`LDST_XLEN-1:0]           dc_st_data_o
);

  import ldst_pkg::*;

  logic [`LDST_XLEN-1:0]     addr_q [`LDST_SQ_DEPTH];
  logic [`LDST_XLEN-1:0]     data_q [`LDST_SQ_DEPTH];
  logic [`LDST_SQ_DEPTH-1:0] vld_q;
  logic [`LDST_SQ_DEPTH-1:0] ret_q;    // Retired by the ROB
  logic [`LDST_SQ_IDX_W-1:0] head_q;
  logic [`LDST_SQ_IDX_W-1:0] retp_q;   // Oldest unretired entry
  logic [`LDST_SQ_IDX_W-1:0] tail_q;
  logic                      drain;

  assign sq_full_o    = vld_q[tail_q];
  assign st_acc_o     = (op_i == MEM_ST) && !flush_i && !sq_full_o;
  assign st_rob_idx_o = rob_idx_i;

  // Head store goes out once retired, held off by stall
  assign drain        = vld_q[head_q] && ret_q[head_q] && !dc_st_stall_i;
  assign dc_st_en_o   = drain;
  assign dc_st_addr_o = addr_q[head_q];
  assign dc_st_data_o = data_q[head_q];

  always_ff @(posedge clk) begin
    if (st_acc_o) begin
      addr_q[tail_q] <= addr_i;
      data_q[tail_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q  <= '0;
      ret_q  <= '0;
      head_q <= '0;
      retp_q <= '0;
      tail_q <= '0;
    end else begin
      if (drain) begin
        vld_q[head_q] <= 1'b0;
        ret_q[head_q] <= 1'b0;
        head_q        <= head_q + 1'b1;
      end
      if (rob_st_retire_i) begin
        ret_q[retp_q] <= 1'b1;
        retp_q        <= retp_q + 1'b1;
      end
      if (flush_i) begin
        // Drop everything not yet retired, this cycle's retire survives
        for (int i = 0; i < `LDST_SQ_DEPTH; i++) begin
          if (!ret_q[i] && !(rob_st_retire_i && retp_q == `LDST_SQ_IDX_W'(i))) begin
            vld_q[i] <= 1'b0;
          end
        end
        tail_q <= retp_q + `LDST_SQ_IDX_W'(rob_st_retire_i);
      end else if (st_acc_o) begin
        vld_q[tail_q] <= 1'b1;
        tail_q        <= tail_q + 1'b1;
      end
    end
  end

  // Walk oldest to youngest so the youngest match wins
  always_comb begin
    logic [`LDST_SQ_IDX_W-1:0] idx;
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    idx        = tail_q;
    for (int k = 0; k < `LDST_SQ_DEPTH; k++) begin
      idx = tail_q + `LDST_SQ_IDX_W'(k);
      if (vld_q[idx] && (addr_q[idx][`LDST_XLEN-1:3] == fwd_addr_i[`LDST_XLEN-1:3])) begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = data_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/load_unit.sv
// Load sequencing

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module load_unit (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       flush_i,
  input  wire ldst_pkg::mem_op_e          op_i,
  input  wire logic [`LDST_XLEN-1:0]      addr_i,
  input  wire logic [`LDST_PRF_IDX_W-1:0] dest_tag_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] rob_idx_i,
  input  wire logic                       fwd_hit_i,
  input  wire logic [`LDST_XLEN-1:0]      fwd_data_i,
  input  wire logic                       dc_ld_ack_i,
  input  wire logic [`LDST_XLEN-1:0]      dc_ld_data_i,
  output logic [`LDST_XLEN-1:0]           fwd_addr_o,
  output logic                            ldst_rdy_o,
  output logic                            dc_ld_en_o,
  output logic [`LDST_XLEN-1:0]           dc_ld_addr_o,
  output logic                            ld_res_vld_o,
  output logic [`LDST_XLEN-1:0]           ld_res_data_o,
  output logic [`LDST_PRF_IDX_W-1:0]      ld_res_tag_o,
  output logic [`LDST_ROB_IDX_W-1:0]      ld_res_rob_o
);

  import ldst_pkg::*;

  ld_state_e                  state_q, state_d;
  logic [`LDST_PRF_IDX_W-1:0] tag_q;
  logic [`LDST_ROB_IDX_W-1:0] rob_q;
  logic                       idle;
  logic                       ld_req;

  assign idle       = (state_q == LD_IDLE);
  assign fwd_addr_o = addr_i;
  // Miss in the store queue goes to the cache
  assign ld_req       = idle && (op_i == MEM_LD) && !fwd_hit_i && !flush_i;
  assign dc_ld_en_o   = ld_req;
  assign dc_ld_addr_o = addr_i;
  assign ldst_rdy_o   = idle ? !ld_req : dc_ld_ack_i;

  assign ld_res_vld_o  = idle ? ((op_i == MEM_LD) && fwd_hit_i)
                              : ((state_q == LD_WAIT) && dc_ld_ack_i);
  assign ld_res_data_o = idle ? fwd_data_i : dc_ld_data_i;
  assign ld_res_tag_o  = idle ? dest_tag_i : tag_q;
  assign ld_res_rob_o  = idle ? rob_idx_i : rob_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (ld_req) begin
          state_d = LD_WAIT;
        end
      end
      LD_WAIT: begin
        if (dc_ld_ack_i) begin
          state_d = LD_IDLE;
        end else if (flush_i) begin
          state_d = LD_DISCARD;
        end
      end
      LD_DISCARD: begin
        if (dc_ld_ack_i) begin
          state_d = LD_IDLE;
        end
      end
      default: state_d = LD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_req) begin  // Hold tags while the read is out
      tag_q <= dest_tag_i;
      rob_q <= rob_idx_i;
    end
  end

endmodule

`default_nettype wire

// File: source/ldst_writeback.sv
// Result broadcast register

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module ldst_writeback (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       flush_i,
  input  wire logic                       ld_res_vld_i,
  input  wire logic [`LDST_XLEN-1:0]      ld_res_data_i,
  input  wire logic [`LDST_PRF_IDX_W-1:0] ld_res_tag_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] ld_res_rob_i,
  input  wire logic                       st_acc_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] st_rob_idx_i,
  output logic [`LDST_XLEN-1:0]           result_o,
  output logic [`LDST_PRF_IDX_W-1:0]      dest_tag_o,
  output logic [`LDST_ROB_IDX_W-1:0]      rob_idx_o,
  output logic [`LDST_ROB_IDX_W-1:0]      st_rob_idx_o,
  output logic                            ld_done_o,
  output logic                            st_done_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_done_o <= 1'b0;
      st_done_o <= 1'b0;
    end else if (flush_i) begin
      ld_done_o <= 1'b0;
      st_done_o <= 1'b0;
    end else begin
      ld_done_o <= ld_res_vld_i;
      st_done_o <= st_acc_i;
    end
  end

  // Load and store fields kept apart, both may finish together
  always_ff @(posedge clk) begin
    if (ld_res_vld_i) begin
      result_o   <= ld_res_data_i;
      dest_tag_o <= ld_res_tag_i;
      rob_idx_o  <= ld_res_rob_i;
    end
    if (st_acc_i) begin
      st_rob_idx_o <= st_rob_idx_i;
    end
  end

endmodule

`default_nettype wire

// File: source/fu_ldst.sv
// Load/store functional unit

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module fu_ldst (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire ldst_pkg::mem_op_e          op_i,
  input  wire logic [`LDST_XLEN-1:0]      opa_i,
  input  wire logic [`LDST_XLEN-1:0]      opb_i,
  input  wire logic [15:0]                imm_i,
  input  wire logic [`LDST_PRF_IDX_W-1:0] dest_tag_i,
  input  wire logic [`LDST_ROB_IDX_W-1:0] rob_idx_i,
  input  wire logic                       rob_st_retire_i,
  input  wire logic                       flush_i,
  input  wire logic                       dc_ld_ack_i,
  input  wire logic [`LDST_XLEN-1:0]      dc_ld_data_i,
  input  wire logic                       dc_st_stall_i,
  output logic [`LDST_XLEN-1:0]           result_o,
  output logic [`LDST_PRF_IDX_W-1:0]      dest_tag_o,
  output logic [`LDST_ROB_IDX_W-1:0]      rob_idx_o,
  output logic [`LDST_ROB_IDX_W-1:0]      st_rob_idx_o,
  output logic                            ld_done_o,
  output logic                            st_done_o,
  output logic                            ldst_rdy_o,
  output logic                            sq_full_o,
  output logic                            dc_ld_en_o,
  output logic [`LDST_XLEN-1:0]           dc_ld_addr_o,
  output logic                            dc_st_en_o,
  output logic [`LDST_XLEN-1:0]           dc_st_addr_o,
  output logic [`LDST_XLEN-1:0]           dc_st_data_o
);

  import ldst_pkg::*;

  mem_op_e                    ag_op;
  logic [`LDST_XLEN-1:0]      ag_addr;
  logic [`LDST_XLEN-1:0]      ag_data;
  logic [`LDST_PRF_IDX_W-1:0] ag_tag;
  logic [`LDST_ROB_IDX_W-1:0] ag_rob;
  logic [`LDST_XLEN-1:0]      fwd_addr;
  logic                       fwd_hit;
  logic [`LDST_XLEN-1:0]      fwd_data;
  logic                       ld_vld;
  logic [`LDST_XLEN-1:0]      ld_data;
  logic [`LDST_PRF_IDX_W-1:0] ld_tag;
  logic [`LDST_ROB_IDX_W-1:0] ld_rob;
  logic                       st_acc;
  logic [`LDST_ROB_IDX_W-1:0] st_rob;

  ldst_agen u_agen (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .op_i       (op_i),
    .opa_i      (opa_i),
    .opb_i      (opb_i),
    .imm_i      (imm_i),
    .dest_tag_i (dest_tag_i),
    .rob_idx_i  (rob_idx_i),
    .op_o       (ag_op),
    .addr_o     (ag_addr),
    .data_o     (ag_data),
    .dest_tag_o (ag_tag),
    .rob_idx_o  (ag_rob)
  );

  store_queue u_sq (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .op_i            (ag_op),
    .addr_i          (ag_addr),
    .data_i          (ag_data),
    .rob_idx_i       (ag_rob),
    .rob_st_retire_i (rob_st_retire_i),
    .fwd_addr_i      (fwd_addr),
    .dc_st_stall_i   (dc_st_stall_i),
    .fwd_hit_o       (fwd_hit),
    .fwd_data_o      (fwd_data),
    .st_acc_o        (st_acc),
    .st_rob_idx_o    (st_rob),
    .sq_full_o       (sq_full_o),
    .dc_st_en_o      (dc_st_en_o),
    .dc_st_addr_o    (dc_st_addr_o),
    .dc_st_data_o    (dc_st_data_o)
  );

  load_unit u_ld (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .op_i          (ag_op),
    .addr_i        (ag_addr),
    .dest_tag_i    (ag_tag),
    .rob_idx_i     (ag_rob),
    .fwd_hit_i     (fwd_hit),
    .fwd_data_i    (fwd_data),
    .dc_ld_ack_i   (dc_ld_ack_i),
    .dc_ld_data_i  (dc_ld_data_i),
    .fwd_addr_o    (fwd_addr),
    .ldst_rdy_o    (ldst_rdy_o),
    .dc_ld_en_o    (dc_ld_en_o),
    .dc_ld_addr_o  (dc_ld_addr_o),
    .ld_res_vld_o  (ld_vld),
    .ld_res_data_o (ld_data),
    .ld_res_tag_o  (ld_tag),
    .ld_res_rob_o  (ld_rob)
  );

  ldst_writeback u_wb (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .ld_res_vld_i  (ld_vld),
    .ld_res_data_i (ld_data),
    .ld_res_tag_i  (ld_tag),
    .ld_res_rob_i  (ld_rob),
    .st_acc_i      (st_acc),
    .st_rob_idx_i  (st_rob),
    .result_o      (result_o),
    .dest_tag_o    (dest_tag_o),
    .rob_idx_o     (rob_idx_o),
    .st_rob_idx_o  (st_rob_idx_o),
    .ld_done_o     (ld_done_o),
    .st_done_o     (st_done_o)
  );

endmodule

`default_nettype wire

// File: dv/fu_ldst_properties.sv
// Load/store unit port assertions

`timescale 1ns/1ps
`default_nettype none

module fu_ldst_properties (
  input wire logic              clk,
  input wire logic              rst,
  input wire ldst_pkg::mem_op_e op_i,
  input wire logic              ldst_rdy_o,
  input wire logic              dc_ld_en_o,
  input wire logic              dc_st_en_o,
  input wire logic              dc_st_stall_i
);

  import ldst_pkg::*;

  // A cache read only follows an issue slot with the unit ready
  a_ld_after_ready: assert property (@(posedge clk) disable iff (rst)
    dc_ld_en_o |-> $past(ldst_rdy_o))
    else $error("dc_ld_en_o without ldst_rdy_o in the issue cycle");

  a_st_no_stall: assert property (@(posedge clk) disable iff (rst)
    dc_st_en_o |-> !dc_st_stall_i)
    else $error("dc_st_en_o during dc_st_stall_i");

  // Load issued while busy
  a_busy_load: assert property (@(posedge clk) disable iff (rst)
    (op_i == MEM_LD && !ldst_rdy_o) |=> !dc_ld_en_o)
    else $error("cache read from a load issued while busy");

endmodule

bind fu_ldst fu_ldst_properties u_props (.*);

`default_nettype wire

// File: dv/tb_fu_ldst.sv
// Load/store unit testbench

`timescale 1ns/1ps
`default_nettype none

`include "ldst_consts.svh"

module tb_fu_ldst;

  import ldst_pkg::*;

  localparam int          NUM_CYC  = 600;
  localparam int          TIMEOUT  = 20 * NUM_CYC;
  localparam logic [63:0] BASE     = 64'h0000_0000_8000_1000;
  localparam logic [63:0] INIT_KEY = 64'h5a5a_c3c3_0f0f_9696;

  logic                       clk;
  logic                       rst;
  mem_op_e                    op_i;
  logic [`LDST_XLEN-1:0]      opa_i;
  logic [`LDST_XLEN-1:0]      opb_i;
  logic [15:0]                imm_i;
  logic [`LDST_PRF_IDX_W-1:0] dest_tag_i;
  logic [`LDST_ROB_IDX_W-1:0] rob_idx_i;
  logic                       rob_st_retire_i;
  logic                       flush_i;
  logic                       dc_ld_ack_i;
  logic [`LDST_XLEN-1:0]      dc_ld_data_i;
  logic                       dc_st_stall_i;
  logic [`LDST_XLEN-1:0]      result_o;
  logic [`LDST_PRF_IDX_W-1:0] dest_tag_o;
  logic [`LDST_ROB_IDX_W-1:0] rob_idx_o;
  logic [`LDST_ROB_IDX_W-1:0] st_rob_idx_o;
  logic                       ld_done_o;
  logic                       st_done_o;
  logic                       ldst_rdy_o;
  logic                       sq_full_o;
  logic                       dc_ld_en_o;
  logic [`LDST_XLEN-1:0]      dc_ld_addr_o;
  logic                       dc_st_en_o;
  logic [`LDST_XLEN-1:0]      dc_st_addr_o;
  logic [`LDST_XLEN-1:0]      dc_st_data_o;

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          n_ld;
  int          n_st;
  int          cyc;
  int          tmo_cnt;
  logic [63:0] sl_addr [$];  // Surviving stores in program order
  logic [63:0] sl_data [$];
  int          n_ret;
  int          n_drained;
  logic [63:0] le_data [$];  // Expected load completions
  logic [5:0]  le_tag [$];
  logic [4:0]  le_rob [$];
  int          le_due [$];
  logic [4:0]  se_rob [$];   // Expected store completions
  int          se_due [$];
  logic [63:0] mem_arr [8];
  mem_op_e     ag_op;        // Issued last cycle
  logic        ag_bad;       // Load issued while busy
  logic [63:0] ag_addr;
  logic [63:0] ag_data;
  logic [5:0]  ag_tag;
  logic [4:0]  ag_rob;
  logic        pm_vld;       // Outstanding cache read
  logic        pm_disc;
  logic [63:0] pm_exp;
  logic [63:0] pm_cache;
  logic [5:0]  pm_tag;
  logic [4:0]  pm_rob;
  int          ack_at;

  fu_ldst u_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    tmo_cnt <= tmo_cnt + 1;
    if (tmo_cnt > TIMEOUT) begin
      $display("Timeout after %0d cycles, unit did not go quiet", tmo_cnt);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [63:0] init_word(input logic [63:0] a);
    return a ^ INIT_KEY;
  endfunction

  function automatic logic [2:0] slot_of(input logic [63:0] a);
    return a[5:3];
  endfunction

  // Youngest surviving store wins and forwards until it drains
  function automatic logic [63:0] expected_load(input logic [63:0] a, input int live,
                                                output logic fwd);
    logic [63:0] v;
    v   = init_word(a);
    fwd = 1'b0;
    for (int i = 0; i < sl_addr.size(); i++) begin
      if (sl_addr[i] == a) begin
        v   = sl_data[i];
        fwd = (i >= live);
      end
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at cycle %0d: %s", cyc, msg);
  endtask

  task automatic check_cycle();
    logic [63:0] ev;
    logic        fwd;
    logic        exp_en;
    logic [63:0] d;
    logic [5:0]  t;
    logic [4:0]  rb;
    int          live;
    exp_en = 1'b0;
    live   = n_drained;  // Head still forwards on its drain cycle
    compare_value("sq_full_o", 64'(sq_full_o),
                  64'((sl_addr.size() - n_drained) == `LDST_SQ_DEPTH));
    if (dc_st_en_o) begin
      if (dc_st_stall_i) report_error("store drained during a stall");
      if (n_drained >= n_ret) begin
        report_error("store drained before it was retired");
      end else begin
        compare_value("dc_st_addr_o", dc_st_addr_o, sl_addr[n_drained]);
        compare_value("dc_st_data_o", dc_st_data_o, sl_data[n_drained]);
        mem_arr[slot_of(dc_st_addr_o)] = dc_st_data_o;
        n_drained++;
      end
    end else if (n_drained < n_ret && !dc_st_stall_i) begin
      report_error("retired head store did not drain");
    end
    if (le_due.size() > 0 && le_due[0] == cyc) begin
      d  = le_data.pop_front();
      t  = le_tag.pop_front();
      rb = le_rob.pop_front();
      void'(le_due.pop_front());
      if (!ld_done_o) begin
        report_error("expected ld_done_o did not come");
      end else begin
        compare_value("result_o", result_o, d);
        compare_value("dest_tag_o", 64'(dest_tag_o), 64'(t));
        compare_value("rob_idx_o", 64'(rob_idx_o), 64'(rb));
      end
    end else if (ld_done_o) begin
      report_error("unexpected ld_done_o");
    end
    if (se_due.size() > 0 && se_due[0] == cyc) begin
      rb = se_rob.pop_front();
      void'(se_due.pop_front());
      if (!st_done_o) report_error("expected st_done_o did not come");
      else compare_value("st_rob_idx_o", 64'(st_rob_idx_o), 64'(rb));
    end else if (st_done_o) begin
      report_error("unexpected st_done_o");
    end
    if (rob_st_retire_i) n_ret++;
    if (pm_vld) begin
      if (dc_ld_ack_i) begin
        compare_value("ldst_rdy_o", 64'(ldst_rdy_o), 64'd1);
        if (!pm_disc && !flush_i) begin
          le_data.push_back(pm_exp);
          le_tag.push_back(pm_tag);
          le_rob.push_back(pm_rob);
          le_due.push_back(cyc + 1);
        end
        pm_vld = 1'b0;
      end else begin
        compare_value("ldst_rdy_o", 64'(ldst_rdy_o), 64'd0);  // Busy while the read is out
      end
    end
    if (flush_i) begin
      while (sl_addr.size() > n_ret) begin
        d = sl_addr.pop_back();
        d = sl_data.pop_back();
      end
      if (pm_vld) pm_disc = 1'b1;
    end else if (ag_op == MEM_ST) begin
      sl_addr.push_back(ag_addr);
      sl_data.push_back(ag_data);
      se_rob.push_back(ag_rob);
      se_due.push_back(cyc + 1);
      n_st++;
    end else if (ag_op == MEM_LD && !ag_bad) begin
      ev = expected_load(ag_addr, live, fwd);
      n_ld++;
      if (fwd) begin
        le_data.push_back(ev);
        le_tag.push_back(ag_tag);
        le_rob.push_back(ag_rob);
        le_due.push_back(cyc + 1);
      end else begin
        exp_en = 1'b1;
        compare_value("dc_ld_addr_o", dc_ld_addr_o, ag_addr);
        compare_value("ldst_rdy_o", 64'(ldst_rdy_o), 64'd0);
        pm_vld   = 1'b1;
        pm_disc  = 1'b0;
        pm_exp   = ev;
        pm_tag   = ag_tag;
        pm_rob   = ag_rob;
        pm_cache = mem_arr[slot_of(ag_addr)];
        ack_at   = cyc + 1 + int'(next_rand() % 32'd4);
      end
    end
    compare_value("dc_ld_en_o", 64'(dc_ld_en_o), 64'(exp_en));
  endtask

  task automatic run_cycle(input logic issue_en);
    logic [31:0] r;
    logic [63:0] tgt;
    logic        st_ok;
    logic        ld_ok;
    logic        bad_ld;
    mem_op_e     nx_op;
    @(negedge clk);
    cyc++;
    r = next_rand();
    flush_i         = issue_en && (r[4:0] == 5'd0);
    dc_st_stall_i   = (r[7:6] == 2'b00);
    rob_st_retire_i = (n_ret < sl_addr.size()) && (r[9:8] != 2'b00);
    dc_ld_ack_i     = pm_vld && (ack_at == cyc);
    dc_ld_data_i    = dc_ld_ack_i ? pm_cache : {next_rand(), next_rand()};
    r = next_rand();
    tgt = BASE + {58'd0, r[2:0], 3'd0};  // One of 8 doubleword slots
    imm_i      = r[31:16];
    opb_i      = tgt - {{48{r[31]}}, r[31:16]};
    opa_i      = {next_rand(), next_rand()};
    dest_tag_i = r[8:3];
    rob_idx_i  = r[13:9];
    st_ok = (sl_addr.size() - n_drained + ((ag_op == MEM_ST) ? 1 : 0)) < `LDST_SQ_DEPTH;
    ld_ok = (ag_op != MEM_LD) && !pm_vld;
    nx_op  = MEM_NOP;
    bad_ld = 1'b0;
    if (issue_en && !flush_i) begin
      if (r[15:14] == 2'b01 && ld_ok) begin
        nx_op = MEM_LD;
      end else if (r[15:14] == 2'b01 && pm_vld && !dc_ld_ack_i) begin
        nx_op  = MEM_LD;  // Unit busy, the load must be ignored
        bad_ld = 1'b1;
      end else if (r[15] && st_ok) begin
        nx_op = MEM_ST;
      end
    end
    op_i = nx_op;
    #1;
    check_cycle();
    ag_op   = nx_op;
    ag_bad  = bad_ld;
    ag_addr = tgt;
    ag_data = opa_i;
    ag_tag  = dest_tag_i;
    ag_rob  = rob_idx_i;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    op_i = MEM_NOP;
    opa_i = '0;
    opb_i = '0;
    imm_i = '0;
    dest_tag_i = '0;
    rob_idx_i = '0;
    rob_st_retire_i = 1'b0;
    flush_i = 1'b0;
    dc_ld_ack_i = 1'b0;
    dc_ld_data_i = '0;
    dc_st_stall_i = 1'b0;
    rng = 32'h180ade4f;
    errors = 0;
    checks = 0;
    n_ld = 0;
    n_st = 0;
    cyc = 0;
    tmo_cnt = 0;
    n_ret = 0;
    n_drained = 0;
    ag_op = MEM_NOP;
    ag_bad = 1'b0;
    pm_vld = 1'b0;
    pm_disc = 1'b0;
    for (int i = 0; i < 8; i++) begin
      mem_arr[i] = init_word(BASE + 64'(i) * 64'd8);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    compare_value("ldst_rdy_o", 64'(ldst_rdy_o), 64'd1);
    compare_value("dc_st_en_o", 64'(dc_st_en_o), 64'd0);
    for (int n = 0; n < NUM_CYC; n++) begin
      run_cycle(1'b1);
    end
    run_cycle(1'b0);
    run_cycle(1'b0);
    // Let retired stores drain and outstanding results land
    while (n_drained != sl_addr.size() || pm_vld || le_due.size() > 0 || se_due.size() > 0) begin
      run_cycle(1'b0);
    end
    $display("Checks %0d, errors %0d, loads %0d, stores %0d", checks, errors, n_ld, n_st);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
source/ldst_pkg.sv
source/ldst_agen.sv
source/store_queue.sv
source/load_unit.sv
source/ldst_writeback.sv
source/fu_ldst.sv
dv/fu_ldst_properties.sv
dv/tb_fu_ldst.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fu_ldst
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
